//--- include/fpRound_defs.svh
`ifndef FPROUND_DEFS_SVH
`define FPROUND_DEFS_SVH

// --------------------
// binary32 field widths
// --------------------
`define FP_EXP_W   8    // biased exponent
`define FP_FRAC_W  23   // stored fraction, hidden bit excluded

// --------------------
// array shape
// --------------------
`define FP_LANES   4    // rounding lanes per beat

// global mode register after reset, nearest ties to even
`define FP_RM_DEFAULT 0

`endif

//--- src/fpRoundPkg.sv
`include "fpRound_defs.svh"

package fpRoundPkg;

	// --------------------
	// field widths
	// --------------------
	typedef logic [`FP_EXP_W-1:0]  fpExp;      // biased exponent
	typedef logic [`FP_FRAC_W-1:0] fpFrac;     // stored fraction
	typedef logic [`FP_FRAC_W+3:0] fpIntMant;  // hidden, fraction, guard, round, sticky
	typedef logic [2:0]            roundMode;  // 0..4 IEEE modes, 5/6 truncate, 7 dynamic

	// unrounded operand, 36 bits
	typedef struct packed {
		logic     sign;
		fpExp     exp;
		fpIntMant mant;
	} fpInter;

	// packed binary32 result
	typedef struct packed {
		logic  sign;
		fpExp  exp;
		fpFrac frac;
	} fpWord;

	typedef struct packed {
		fpInter   opnd;
		roundMode mode;   // resolved by the dispatcher before it reaches a lane
	} laneOp;

	typedef struct packed {
		fpWord word;
		logic  inexact;
		logic  overflow;
	} laneRes;

	typedef struct packed {
		logic inexact;
		logic overflow;
	} fpFlags;

endpackage

//--- src/roundDispatch.sv
`include "fpRound_defs.svh"

module roundDispatch (
	input  logic                   clk,
	input  logic                   rstN,
	input  logic                   ce,
	input  logic                   inValid,
	input  fpRoundPkg::laneOp      ops [`FP_LANES],
	input  fpRoundPkg::roundMode   globalMode,
	input  logic                   globalModeWr,
	output fpRoundPkg::laneOp      laneOpQ [`FP_LANES],
	output logic                   dispValid
);
	import fpRoundPkg::*;

	localparam roundMode RM_DYN = 3'd7;  // lane asks for the global mode

	roundMode gMode;                      // global mode register
	laneOp    opRes [`FP_LANES];          // requests with the mode resolved

	// --------------------
	// global mode register
	// --------------------
	// written regardless of ce
	// a beat registered in the same cycle still picks up the old value
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			gMode <= roundMode'(`FP_RM_DEFAULT);
		else if (globalModeWr)
			gMode <= globalMode;
	end

	// --------------------
	// mode resolution
	// --------------------
	always_comb begin
		for (int i = 0; i < `FP_LANES; i++) begin
			opRes[i] = ops[i];              // operand goes through untouched
			if (ops[i].mode == RM_DYN)
				opRes[i].mode = gMode;      // dynamic takes the current global mode
		end
	end

	// operand register
	always_ff @(posedge clk) begin
		if (ce)
			laneOpQ <= opRes;
	end

	// valid travels alongside the operands
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			dispValid <= 1'b0;
		else if (ce)
			dispValid <= inValid;
	end

endmodule

//--- src/fpRoundLane.sv
`include "fpRound_defs.svh"

module fpRoundLane (
	input  logic               clk,
	input  logic               rstN,
	input  logic               ce,
	input  logic               validIn,
	input  fpRoundPkg::laneOp  op,
	output fpRoundPkg::laneRes res,
	output logic               validOut
);
	import fpRoundPkg::*;

	localparam int FW = `FP_FRAC_W;
	localparam int EW = `FP_EXP_W;

	// --------------------
	// operand fields
	// --------------------
	logic     sgn;
	fpExp     expIn;
	fpIntMant mant;
	fpFrac    fracIn;
	logic     hid;       // hidden bit
	logic     lsb;       // fraction lsb, decides ties to even
	logic     grd;       // guard
	logic     rb;        // round
	logic     stk;       // sticky
	logic     xInf;      // exponent all ones, inf or NaN
	logic     dn;        // denormal or zero
	logic     tie;       // exactly half an ulp lost
	logic     anyLost;   // something below the lsb was nonzero

	assign sgn     = op.opnd.sign;
	assign expIn   = op.opnd.exp;
	assign mant    = op.opnd.mant;
	assign hid     = mant[FW+3];
	assign fracIn  = mant[FW+2:3];
	assign lsb     = mant[3];
	assign grd     = mant[2];
	assign rb      = mant[1];
	assign stk     = mant[0];
	assign xInf    = &expIn;
	assign dn      = (expIn == '0);
	assign tie     = grd & ~(rb | stk);
	assign anyLost = grd | rb | stk;

	// --------------------
	// round bit
	// --------------------
	logic rnd;

	always_comb begin
		rnd = 1'b0;
		if (!xInf) begin                                // inf and NaN never round
			case (op.mode)
				3'd0: rnd = (grd & (rb | stk)) | (lsb & tie); // nearest, ties to even
				3'd1: rnd = 1'b0;                           // toward zero
				3'd2: rnd = anyLost & ~sgn;                 // toward +inf
				3'd3: rnd = anyLost & sgn;                  // toward -inf
				3'd4: rnd = grd;                            // nearest, ties away
				default: rnd = 1'b0;                        // 5 and 6 truncate
			endcase
		end
	end

	// --------------------
	// add and carry
	// --------------------
	logic [FW+1:0] mantSum;   // carry out, hidden, fraction
	logic          carry;     // 1.11..1 rolled over to 10.0
	logic          dnUp;      // denormal grew a hidden bit
	logic          bump;      // exponent increments
	fpExp          expRnd;
	logic          expMax;    // rounded exponent hit all ones
	fpFrac         fracRnd;

	assign mantSum = {1'b0, hid, fracIn} + {{(FW+1){1'b0}}, rnd};
	assign carry   = mantSum[FW+1];
	assign dnUp    = dn & mantSum[FW];
	assign bump    = rnd & (carry | dnUp);
	assign expRnd  = expIn + {{(EW-1){1'b0}}, bump};
	assign expMax  = &expRnd;

	// stored fraction for each case of rounding, carry and denormal
	always_comb begin
		casez ({rnd, expMax, carry, dn})
			4'b0???: fracRnd = fracIn;               // no rounding, fraction as is
			4'b11??: fracRnd = '0;                   // rounded up to infinity
			4'b1000: fracRnd = mantSum[FW-1:0];      // normal, exponent unchanged
			4'b1001: fracRnd = mantSum[FW-1:0];      // denormal, hidden bit moved to exp
			4'b101?: fracRnd = mantSum[FW:1];        // carry, renormalize by one
			default: fracRnd = fracIn;
		endcase
	end

	// --------------------
	// output register
	// --------------------
	always_ff @(posedge clk) begin
		if (ce) begin
			res.word.sign <= sgn;
			res.word.exp  <= expRnd;                 // equals expIn when nothing carried
			res.word.frac <= fracRnd;
			res.inexact   <= ~xInf & anyLost;
			res.overflow  <= rnd & expMax;           // rnd already excludes inf/NaN
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			validOut <= 1'b0;
		else if (ce)
			validOut <= validIn;
	end

endmodule

//--- src/roundCollect.sv
`include "fpRound_defs.svh"

module roundCollect (
	input  logic                clk,
	input  logic                rstN,
	input  logic                ce,
	input  logic                laneValid,
	input  fpRoundPkg::laneRes  laneRes [`FP_LANES],
	input  logic                flagClr,
	output logic                outValid,
	output fpRoundPkg::fpWord   results [`FP_LANES],
	output fpRoundPkg::fpFlags  flags [`FP_LANES],
	output fpRoundPkg::fpFlags  stickyFlags
);
	import fpRoundPkg::*;

	fpFlags laneOr;     // flags ORed across all lanes of this beat
	fpFlags newFlags;   // what gets merged into the sticky register

	// --------------------
	// lane reduction
	// --------------------
	always_comb begin
		laneOr = '0;
		for (int i = 0; i < `FP_LANES; i++) begin
			laneOr.inexact  = laneOr.inexact  | laneRes[i].inexact;
			laneOr.overflow = laneOr.overflow | laneRes[i].overflow;
		end
	end

	// only a valid, enabled beat contributes
	assign newFlags = (ce && laneValid) ? laneOr : '0;

	// results and per-beat flags
	always_ff @(posedge clk) begin
		if (ce) begin
			for (int i = 0; i < `FP_LANES; i++) begin
				results[i]        <= laneRes[i].word;
				flags[i].inexact  <= laneRes[i].inexact;
				flags[i].overflow <= laneRes[i].overflow;
			end
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			outValid <= 1'b0;
		else if (ce)
			outValid <= laneValid;
	end

	// --------------------
	// sticky flags
	// --------------------
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			stickyFlags <= '0;
		else if (flagClr)
			stickyFlags <= newFlags;                  // flags arriving now outlive the clear
		else
			stickyFlags <= stickyFlags | newFlags;
	end

endmodule

//--- src/fpRoundArray.sv
`include "fpRound_defs.svh"

module fpRoundArray (
	input  logic                  clk,
	input  logic                  rstN,
	input  logic                  ce,
	input  logic                  inValid,
	input  fpRoundPkg::laneOp     ops [`FP_LANES],
	input  fpRoundPkg::roundMode  globalMode,
	input  logic                  globalModeWr,
	input  logic                  flagClr,
	output logic                  outValid,
	output fpRoundPkg::fpWord     results [`FP_LANES],
	output fpRoundPkg::fpFlags    flags [`FP_LANES],
	output fpRoundPkg::fpFlags    stickyFlags
);
	import fpRoundPkg::*;

	laneOp                laneOpQ [`FP_LANES];   // dispatcher -> lanes
	laneRes               laneResQ [`FP_LANES];  // lanes -> collector
	logic [`FP_LANES-1:0] laneValid;             // per-lane valid copies, lane 0 drives on
	logic                 dispValid;

	// stage 1, register beat and resolve modes
	roundDispatch uDispatch (
		.clk          (clk),
		.rstN         (rstN),
		.ce           (ce),
		.inValid      (inValid),
		.ops          (ops),
		.globalMode   (globalMode),
		.globalModeWr (globalModeWr),
		.laneOpQ      (laneOpQ),
		.dispValid    (dispValid)
	);

	// stage 2, one rounder per lane
	for (genvar g = 0; g < `FP_LANES; g++) begin : gLane
		fpRoundLane uLane (
			.clk      (clk),
			.rstN     (rstN),
			.ce       (ce),
			.validIn  (dispValid),
			.op       (laneOpQ[g]),
			.res      (laneResQ[g]),
			.validOut (laneValid[g])
		);
	end

	// stage 3, results out plus flag accumulation
	roundCollect uCollect (
		.clk         (clk),
		.rstN        (rstN),
		.ce          (ce),
		.laneValid   (laneValid[0]),
		.laneRes     (laneResQ),
		.flagClr     (flagClr),
		.outValid    (outValid),
		.results     (results),
		.flags       (flags),
		.stickyFlags (stickyFlags)
	);

endmodule

//--- verification/tbClockGen.sv
module tbClockGen #(
	parameter int HALF_PERIOD = 20,   // 40 ns clock
	parameter int RESET_CYCLES = 4
) (
	output logic clk,
	output logic rstN
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD) clk = ~clk;
	end

	// reset low for a few edges, released just after an edge
	initial begin
		rstN = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#2 rstN = 1'b1;
	end

endmodule

//--- verification/fpRoundArrayTb.sv
`include "fpRound_defs.svh"

module fpRoundArrayTb;
	timeunit 1ns;
	timeprecision 100ps;
	import fpRoundPkg::*;

	typedef struct packed {
		logic [`FP_LANES*32-1:0] w;   // expected words with lane i at [i*32 +: 32]
		logic [`FP_LANES*2-1:0]  f;   // {inexact, overflow} per lane
	} beatExp;

	logic clk, rstN, ce, inValid, globalModeWr, flagClr, outValid;
	laneOp    ops [`FP_LANES];
	laneOp    beatOps [`FP_LANES];   // staging for the next beat
	roundMode globalMode;
	fpWord    results [`FP_LANES];
	fpFlags   flags [`FP_LANES];
	fpFlags   stickyFlags;

	logic [31:0]             lfsr = 32'h5633_52e5;
	beatExp                  expQ [$];   // scoreboard
	beatExp                  expCur;
	logic                    chkNow = 1'b0;
	logic                    ceAtEdge = 1'b0;
	logic                    clrSeen = 1'b0;
	logic [2:0]              vPipe;     // inValid delayed by enabled cycles
	fpFlags                  stickyModel = '0;
	roundMode                gModeModel = roundMode'(`FP_RM_DEFAULT);
	logic [`FP_LANES*32-1:0] actWords;
	logic [`FP_LANES*2-1:0]  actFlags;
	int                      errCnt = 0;
	int                      toCnt = 0;

	tbClockGen uClk (.clk(clk), .rstN(rstN));

	fpRoundArray UUT (
		.clk(clk), .rstN(rstN), .ce(ce), .inValid(inValid), .ops(ops),
		.globalMode(globalMode), .globalModeWr(globalModeWr), .flagClr(flagClr),
		.outValid(outValid), .results(results), .flags(flags), .stickyFlags(stickyFlags)
	);

	// flatten outputs so one compare covers every lane
	always_comb begin
		for (int i = 0; i < `FP_LANES; i++) begin
			actWords[i*32 +: 32] = results[i];
			actFlags[i*2 +: 2]   = {flags[i].inexact, flags[i].overflow};
		end
	end

	// --------------------
	// reference model
	// --------------------
	function automatic logic lfsrStep();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];   // taps 32,22,2,1
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] randBits(int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[30:0], lfsrStep()};
		return v;
	endfunction

	function automatic roundMode resolveMode(roundMode m);
		return (m == 3'd7) ? gModeModel : m;
	endfunction

	// returns {word, inexact, overflow}
	function automatic logic [33:0] refRound(fpInter x, roundMode m);
		logic        l, g, r, s, up;
		logic [30:0] mag;
		l = x.mant[3];
		g = x.mant[2];
		r = x.mant[1];
		s = x.mant[0];
		if (&x.exp)
			return {x.sign, x.exp, x.mant[25:3], 2'b00};   // inf/NaN untouched
		case (m)
			3'd0: up = g & (r | s | l);
			3'd2: up = (g | r | s) & ~x.sign;
			3'd3: up = (g | r | s) & x.sign;
			3'd4: up = g;
			default: up = 1'b0;
		endcase
		mag = {x.exp, x.mant[25:3]} + 31'(up);   // carry runs into exponent naturally
		return {x.sign, mag, g | r | s, up & (&mag[30:23])};
	endfunction

	// --------------------
	// scoreboard and checks
	// --------------------
	always @(posedge clk) begin
		ceAtEdge <= ce;
		clrSeen  <= flagClr;
		if (!rstN)
			vPipe <= '0;
		else if (ce)
			vPipe <= {vPipe[1:0], inValid};
	end

	always @(negedge clk) begin
		if (clrSeen)
			stickyModel = '0;
		chkNow = 1'b0;
		if (rstN && outValid && ceAtEdge) begin   // a fresh beat only after an enabled edge
			if (expQ.size() == 0) begin
				$display("outValid rose at %0t with no beat outstanding", $time);
				errCnt++;
			end else begin
				expCur = expQ.pop_front();
				chkNow = 1'b1;
				for (int i = 0; i < `FP_LANES; i++) begin
					stickyModel.inexact  = stickyModel.inexact  | expCur.f[i*2+1];
					stickyModel.overflow = stickyModel.overflow | expCur.f[i*2];
				end
			end
		end
	end

	aWords: assert property (@(posedge clk) disable iff (!rstN) chkNow |-> actWords == expCur.w)
		else begin
			$display("FAIL %0t results %h expected %h", $time, actWords, expCur.w);
			errCnt++;
		end
	aFlags: assert property (@(posedge clk) disable iff (!rstN) chkNow |-> actFlags == expCur.f)
		else begin
			$display("FAIL %0t flags %b expected %b", $time, actFlags, expCur.f);
			errCnt++;
		end
	aValid: assert property (@(posedge clk) disable iff (!rstN) outValid == vPipe[2])
		else begin
			$display("FAIL %0t outValid %b expected %b", $time, outValid, vPipe[2]);
			errCnt++;
		end
	aSticky: assert property (@(posedge clk) disable iff (!rstN) stickyFlags == stickyModel)
		else begin
			$display("FAIL %0t sticky %b expected %b", $time, stickyFlags, stickyModel);
			errCnt++;
		end

	// --------------------
	// stimulus tasks
	// --------------------
	function automatic laneOp randomOp(roundMode m);
		laneOp o;
		o.opnd.sign = 1'(randBits(1));
		o.opnd.exp  = fpExp'(randBits(8));
		if (&o.opnd.exp)
			o.opnd.exp = 8'hfe;                     // keep finite
		o.opnd.mant[25:0] = 26'(randBits(26));
		if (randBits(2) == 0)
			o.opnd.mant[2:0] = 3'b100;              // exact tie
		o.opnd.mant[26] = (o.opnd.exp != 0);        // hidden bit matches exponent
		o.mode = m;
		return o;
	endfunction

	function automatic laneOp fixedOp(logic sg, fpExp e, logic [22:0] fr, logic [2:0] grs,
		roundMode m);
		laneOp o;
		o.opnd.sign = sg;
		o.opnd.exp  = e;
		o.opnd.mant = {(e != 0), fr, grs};
		o.mode      = m;
		return o;
	endfunction

	task automatic sendBeat();
		beatExp      e;
		logic [33:0] r;
		@(posedge clk);
		#2;
		ce      = 1'b1;
		inValid = 1'b1;
		ops     = beatOps;
		for (int i = 0; i < `FP_LANES; i++) begin
			r = refRound(beatOps[i].opnd, resolveMode(beatOps[i].mode));
			e.w[i*32 +: 32] = r[33:2];
			e.f[i*2 +: 2]   = r[1:0];
		end
		expQ.push_back(e);
	endtask

	task automatic idleCycles(int n);
		repeat (n) begin
			@(posedge clk);
			#2;
			inValid = 1'b0;
			flagClr = 1'b0;
			globalModeWr = 1'b0;
		end
	endtask

	task automatic writeGlobalMode(roundMode m);
		@(posedge clk);
		#2;
		inValid      = 1'b0;
		globalMode   = m;
		globalModeWr = 1'b1;
		@(posedge clk);
		#2;
		globalModeWr = 1'b0;
		gModeModel   = m;
	endtask

	task automatic waitResetRelease();
		int waited;
		waited = 0;
		while (rstN !== 1'b1 && waited < 20) begin
			@(posedge clk);
			waited++;
		end
		if (rstN !== 1'b1) begin
			$display("timed out waiting for reset to be released");
			toCnt++;
		end
	endtask

	task automatic drainPipe();
		int waited;
		waited = 0;
		while (expQ.size() != 0 && waited < 50) begin
			idleCycles(1);
			waited++;
		end
		if (expQ.size() != 0) begin
			$display("timed out waiting for %0d outstanding beats", expQ.size());
			toCnt++;
		end
		idleCycles(2);
	endtask

	initial begin
		#400000;
		$display("simulation watchdog expired, run did not finish");
		$display("Simulation FAILED");
		$finish;
	end

	initial begin
		ce = 1'b1;
		inValid = 1'b0;
		globalMode = '0;
		globalModeWr = 1'b0;
		flagClr = 1'b0;
		for (int i = 0; i < `FP_LANES; i++)
			ops[i] = '0;
		waitResetRelease();

		// fixed modes with random operands and ties
		for (int m = 0; m <= 4; m++)
			repeat (20) begin
				for (int i = 0; i < `FP_LANES; i++)
					beatOps[i] = randomOp(roundMode'(m));
				sendBeat();
			end
		drainPipe();

		// dynamic mode and mixed lanes
		for (int g = 2; g <= 4; g++) begin
			writeGlobalMode(roundMode'(g));
			repeat (8) begin
				beatOps[0] = randomOp(3'd7);
				beatOps[1] = randomOp(3'd5);
				beatOps[2] = randomOp(3'd3);
				beatOps[3] = randomOp(3'd6);
				sendBeat();
			end
		end
		drainPipe();

		// flag clear ahead of the carry, denormal and overflow beat
		flagClr = 1'b1;
		idleCycles(1);
		beatOps[0] = fixedOp(1'b0, 8'h05, 23'h7fffff, 3'b111, 3'd2);
		beatOps[1] = fixedOp(1'b0, 8'h00, 23'h7fffff, 3'b100, 3'd0);
		beatOps[2] = fixedOp(1'b1, 8'hfe, 23'h7fffff, 3'b100, 3'd4);
		beatOps[3] = fixedOp(1'b0, 8'hfe, 23'h7fffff, 3'b001, 3'd2);
		sendBeat();
		// infinity and NaN pass through
		beatOps[0] = fixedOp(1'b0, 8'hff, 23'h000000, 3'b111, 3'd2);
		beatOps[1] = fixedOp(1'b1, 8'hff, 23'h000000, 3'b100, 3'd3);
		beatOps[2] = fixedOp(1'b0, 8'hff, 23'h400001, 3'b101, 3'd4);
		beatOps[3] = fixedOp(1'b1, 8'hff, 23'h7fffff, 3'b111, 3'd0);
		sendBeat();
		drainPipe();

		// freeze with beats in flight and clear while results land
		for (int k = 0; k < 3; k++) begin
			for (int i = 0; i < `FP_LANES; i++)
				beatOps[i] = randomOp(roundMode'(k));
			sendBeat();
		end
		@(posedge clk);
		#2;
		ce      = 1'b0;
		inValid = 1'b1;   // must be ignored while frozen
		repeat (5) @(posedge clk);
		#2;
		ce      = 1'b1;
		inValid = 1'b0;
		flagClr = 1'b1;
		idleCycles(1);
		drainPipe();

		$display("checks done, %0d errors, %0d timeouts", errCnt, toCnt);
		if (errCnt == 0 && toCnt == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

//--- build.f
+incdir+include
src/fpRoundPkg.sv
src/roundDispatch.sv
src/fpRoundLane.sv
src/roundCollect.sv
src/fpRoundArray.sv
verification/tbClockGen.sv
verification/fpRoundArrayTb.sv

//--- runSim.sh
#!/usr/bin/env bash
# build and run the rounding array testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	-f build.f \
	--top-module fpRoundArrayTb \
	-o simv \
	|| { echo "build failed"; exit 1; }

./obj_dir/simv | tee /dev/stderr | grep -q "Simulation PASSED" \
	&& { echo "run passed"; exit 0; } \
	|| { echo "run failed"; exit 1; }
